/* src/sbus_cfg.svh */
`ifndef SBUS_CFG_SVH
`define SBUS_CFG_SVH

// data and address widths
`define SBUS_DATA_W 32
`define SBUS_ADDR_W 6

// bus masters sharing the slave
`define SBUS_NUM_MASTERS 3
`define SBUS_MST_W 2 // owner index width

// fixed burst
`define SBUS_BURST_LEN 4
`define SBUS_BEAT_W 2 // log2 of burst length

// memory is 2**SBUS_ADDR_W words, addresses wrap naturally
`define SBUS_MEM_DEPTH 64

// wait states after each address phase
`define SBUS_WAIT_CYCLES 2
`define SBUS_WAIT_W 2

`endif

/* src/sbus_pkg.sv */
`include "sbus_cfg.svh"

package sbus_pkg;

    // command from outside into one master
    typedef struct packed {
        logic                                          write;
        logic [`SBUS_ADDR_W-1:0]                       addr;
        logic [`SBUS_BURST_LEN-1:0][`SBUS_DATA_W-1:0]  data;
    } sbus_cmd_t;

    // completion back to outside
    typedef struct packed {
        logic                                          write;
        logic [`SBUS_BURST_LEN-1:0][`SBUS_DATA_W-1:0]  data;
    } sbus_rsp_t;

    // master to slave lines, address rides on data in the address cycle
    typedef struct packed {
        logic                    addr_phase;
        logic                    write;
        logic                    beat;
        logic [`SBUS_DATA_W-1:0] data;
    } sbus_bus_t;

    // slave to master lines
    typedef struct packed {
        logic                    wait_st; // slave busy
        logic [`SBUS_DATA_W-1:0] data;
    } sbus_slv_t;

    typedef enum logic [2:0] {
        IDLE, REQ, ADDR, WAIT, WRITE, READ, FINISH, RESP
    } mst_state_t;

    typedef enum logic [1:0] {
        SL_IDLE, SL_WAIT, SL_BEAT
    } slv_state_t;

endpackage

/* src/burst_master.sv */
`timescale 1ns/10ps
`include "sbus_cfg.svh"

module burst_master (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  sbus_pkg::sbus_cmd_t cmd,
    output logic                cmd_ready,
    output logic                rsp_valid,
    output sbus_pkg::sbus_rsp_t rsp,
    input  logic                rsp_ready,
    output logic                req,
    input  logic                ack,
    output sbus_pkg::sbus_bus_t bus_out,
    input  sbus_pkg::sbus_slv_t slv_in
);
    import sbus_pkg::*;

    mst_state_t state;
    mst_state_t next_state;

    sbus_cmd_t cmd_q;
    logic [`SBUS_BURST_LEN-1:0][`SBUS_DATA_W-1:0] rd_buf;
    logic [`SBUS_BEAT_W-1:0] cnt;
    logic last_beat;

    assign last_beat = (cnt == `SBUS_BEAT_W'(`SBUS_BURST_LEN - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= next_state;
            if (state == WRITE || state == READ) begin
                cnt <= cnt + 1'b1; // wraps back to 0 after last beat
            end else begin
                cnt <= '0;
            end
        end
    end

    // command latch and read capture
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
        if (state == READ) begin
            rd_buf[cnt] <= slv_in.data;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (cmd_valid) begin
                    next_state = REQ;
                end
            end
            REQ: begin
                if (ack) begin
                    next_state = ADDR;
                end
            end
            ADDR: begin
                next_state = WAIT;
            end
            WAIT: begin
                // leave on first cycle the slave is not busy
                if (!slv_in.wait_st) begin
                    next_state = cmd_q.write ? WRITE : READ;
                end
            end
            WRITE, READ: begin
                if (last_beat) begin
                    next_state = FINISH;
                end
            end
            FINISH: begin
                next_state = RESP;
            end
            RESP: begin
                if (rsp_ready) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // bus lines, zero outside of own phases
    always_comb begin
        bus_out = '0;
        case (state)
            ADDR: begin
                bus_out.addr_phase = 1'b1;
                bus_out.write      = cmd_q.write;
                bus_out.data       = `SBUS_DATA_W'(cmd_q.addr);
            end
            WRITE: begin
                bus_out.beat  = 1'b1;
                bus_out.write = 1'b1;
                bus_out.data  = cmd_q.data[cnt];
            end
            READ: begin
                bus_out.beat = 1'b1; // sampling slave data
            end
            default: begin
                bus_out = '0;
            end
        endcase
    end

    assign req       = (state inside {REQ, ADDR, WAIT, WRITE, READ});
    assign cmd_ready = (state == IDLE);
    assign rsp_valid = (state == RESP);

    assign rsp.write = cmd_q.write;
    assign rsp.data  = rd_buf;

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/10ps
`include "sbus_cfg.svh"

module bus_arbiter (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [`SBUS_NUM_MASTERS-1:0]                 req,
    output logic [`SBUS_NUM_MASTERS-1:0]                 ack,
    input  sbus_pkg::sbus_bus_t [`SBUS_NUM_MASTERS-1:0]  mst_bus,
    output sbus_pkg::sbus_bus_t                          slv_bus
);

    logic                   busy;  // a tenure is active
    logic [`SBUS_MST_W-1:0] owner; // holds the last owner while idle
    logic [`SBUS_MST_W-1:0] pick;
    logic                   found;

    // round-robin search starting after the last owner
    always_comb begin : rr_pick
        int idx;
        found = 1'b0;
        pick  = owner;
        for (int k = 1; k <= `SBUS_NUM_MASTERS; k++) begin
            idx = (int'(owner) + k) % `SBUS_NUM_MASTERS;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = `SBUS_MST_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= `SBUS_MST_W'(`SBUS_NUM_MASTERS - 1); // master 0 goes first
        end else if (busy) begin
            if (!req[owner]) begin
                busy <= 1'b0; // owner released the bus
            end
        end else if (found) begin
            busy  <= 1'b1;
            owner <= pick;
        end
    end

    // registered grant, masked once the owner lets go
    always_comb begin
        for (int i = 0; i < `SBUS_NUM_MASTERS; i++) begin
            ack[i] = busy && (owner == `SBUS_MST_W'(i)) && req[i];
        end
    end

    assign slv_bus = busy ? mst_bus[owner] : '0;

endmodule

/* src/burst_slave_mem.sv */
`timescale 1ns/10ps
`include "sbus_cfg.svh"

module burst_slave_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  sbus_pkg::sbus_bus_t bus_in,
    output sbus_pkg::sbus_slv_t slv_out
);
    import sbus_pkg::*;

    slv_state_t state;

    logic [`SBUS_DATA_W-1:0] mem [`SBUS_MEM_DEPTH];

    logic [`SBUS_ADDR_W-1:0] base;
    logic [`SBUS_ADDR_W-1:0] addr_k;
    logic                    write_q;
    logic [`SBUS_WAIT_W-1:0] wait_cnt;
    logic [`SBUS_BEAT_W-1:0] beat_cnt;
    logic                    last_beat;
    logic                    wr_en;

    assign addr_k    = base + `SBUS_ADDR_W'(beat_cnt); // wraps at depth
    assign last_beat = (beat_cnt == `SBUS_BEAT_W'(`SBUS_BURST_LEN - 1));
    assign wr_en     = (state == SL_BEAT) && write_q && bus_in.beat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SL_IDLE;
            base     <= '0;
            write_q  <= 1'b0;
            wait_cnt <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                SL_IDLE: begin
                    if (bus_in.addr_phase) begin
                        base     <= bus_in.data[`SBUS_ADDR_W-1:0];
                        write_q  <= bus_in.write;
                        wait_cnt <= `SBUS_WAIT_W'(`SBUS_WAIT_CYCLES);
                        beat_cnt <= '0;
                        state    <= SL_WAIT;
                    end
                end
                SL_WAIT: begin
                    // wait drops for one cycle before the first beat
                    if (wait_cnt == '0) begin
                        state <= SL_BEAT;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                SL_BEAT: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat) begin
                        state <= SL_IDLE;
                    end
                end
                default: begin
                    state <= SL_IDLE;
                end
            endcase
        end
    end

    // memory starts out zeroed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SBUS_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[addr_k] <= bus_in.data;
        end
    end

    assign slv_out.wait_st = (state == SL_WAIT) && (wait_cnt != '0);
    assign slv_out.data    = (state == SL_BEAT && !write_q) ? mem[addr_k] : '0;

endmodule

/* src/sbus_top.sv */
`timescale 1ns/10ps
`include "sbus_cfg.svh"

module sbus_top (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [`SBUS_NUM_MASTERS-1:0]                 cmd_valid,
    input  sbus_pkg::sbus_cmd_t [`SBUS_NUM_MASTERS-1:0]  cmd,
    output logic [`SBUS_NUM_MASTERS-1:0]                 cmd_ready,
    output logic [`SBUS_NUM_MASTERS-1:0]                 rsp_valid,
    output sbus_pkg::sbus_rsp_t [`SBUS_NUM_MASTERS-1:0]  rsp,
    input  logic [`SBUS_NUM_MASTERS-1:0]                 rsp_ready
);
    import sbus_pkg::*;

    logic [`SBUS_NUM_MASTERS-1:0] req;
    logic [`SBUS_NUM_MASTERS-1:0] ack;

    sbus_bus_t [`SBUS_NUM_MASTERS-1:0] mst_bus;
    sbus_bus_t                         slv_bus;
    sbus_slv_t                         slv_resp; // broadcast to all masters

    for (genvar i = 0; i < `SBUS_NUM_MASTERS; i++) begin : g_mst
        burst_master u_master (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd_valid (cmd_valid[i]),
            .cmd       (cmd[i]),
            .cmd_ready (cmd_ready[i]),
            .rsp_valid (rsp_valid[i]),
            .rsp       (rsp[i]),
            .rsp_ready (rsp_ready[i]),
            .req       (req[i]),
            .ack       (ack[i]),
            .bus_out   (mst_bus[i]),
            .slv_in    (slv_resp)
        );
    end

    bus_arbiter u_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .ack     (ack),
        .mst_bus (mst_bus),
        .slv_bus (slv_bus)
    );

    burst_slave_mem u_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_in  (slv_bus),
        .slv_out (slv_resp)
    );

endmodule

/* testbench/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk; // 10 ns period
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* testbench/sbus_assertions.sv */
`timescale 1ns/10ps
`include "sbus_cfg.svh"

module sbus_assertions (
    input logic                         clk,
    input logic                         rst_n,
    input logic [`SBUS_NUM_MASTERS-1:0] req,
    input logic [`SBUS_NUM_MASTERS-1:0] ack,
    input sbus_pkg::sbus_bus_t          slv_bus
);

    // wait window of the slave, counted from the address phase
    logic [`SBUS_WAIT_W-1:0] wait_left;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_left <= '0;
        end else if (slv_bus.addr_phase) begin
            wait_left <= `SBUS_WAIT_W'(`SBUS_WAIT_CYCLES);
        end else if (wait_left != '0) begin
            wait_left <= wait_left - 1'b1;
        end
    end

    one_ack: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ack))
        else $error("more than one master holds the bus");

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) (ack & ~req) == '0)
        else $error("grant given to a master that is not requesting");

    addr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        slv_bus.addr_phase |=> !slv_bus.addr_phase)
        else $error("address phase longer than one cycle");

    no_beat_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        !(slv_bus.beat && wait_left != '0))
        else $error("data beat while the slave is in wait");

endmodule

bind bus_arbiter sbus_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .slv_bus (slv_bus)
);

/* testbench/sbus_tb.sv */
`timescale 1ns/10ps
`include "sbus_cfg.svh"

module sbus_tb;
    import sbus_pkg::*;

    localparam int NM          = `SBUS_NUM_MASTERS;
    localparam int N_ENTRIES   = 14;
    localparam int HOLD_CYCLES = 20;
    localparam int TIMEOUT     = N_ENTRIES * 60;

    typedef struct packed {
        logic [3:0]              group; // same tag starts together
        logic [`SBUS_MST_W-1:0]  mst;
        logic                    write;
        logic [`SBUS_ADDR_W-1:0] addr;
        logic                    slow;  // rsp_ready held low
    } entry_t;

    typedef enum logic [2:0] {S_OFF, S_CMD, S_BUSY, S_HOLD, S_TAKE} step_t;

    logic               clk;
    logic               rst_n;
    logic [NM-1:0]      cmd_valid;
    sbus_cmd_t [NM-1:0] cmd;
    logic [NM-1:0]      cmd_ready;
    logic [NM-1:0]      rsp_valid;
    sbus_rsp_t [NM-1:0] rsp;
    logic [NM-1:0]      rsp_ready;

    entry_t                  tbl [N_ENTRIES];
    logic [`SBUS_DATA_W-1:0] model_mem [`SBUS_MEM_DEPTH];
    sbus_cmd_t               sent [NM];
    sbus_rsp_t               held [NM];
    step_t                   step [NM];
    int                      ent [NM];
    int                      hold_left [NM];
    int                      seed;
    int                      n_checks;
    int                      n_errors;
    int                      cycle_cnt;

    clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    sbus_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    task automatic check_val(input string name, input logic [135:0] exp,
                             input logic [135:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    // writes go into the model, reads are compared against it
    task automatic check_response(input int m);
        entry_t e;
        int     a;
        int     k;
        e = tbl[ent[m]];
        check_val($sformatf("rsp[%0d].write", m), 136'(e.write), 136'(rsp[m].write));
        for (k = 0; k < `SBUS_BURST_LEN; k++) begin
            a = (int'(e.addr) + k) % `SBUS_MEM_DEPTH; // wraps at the top
            if (e.write) begin
                model_mem[a] = sent[m].data[k];
            end else begin
                check_val($sformatf("rsp[%0d].data[%0d]", m, k),
                          136'(model_mem[a]), 136'(rsp[m].data[k]));
            end
        end
    endtask

    task automatic run_group(input int first, output int next);
        sbus_cmd_t c;
        int        e;
        int        m;
        int        j;
        int        k;
        int        n_in_group;
        bit        has_slow;
        bit        other_done;
        bit        active;
        e          = first;
        n_in_group = 0;
        has_slow   = 1'b0;
        other_done = 1'b0;
        while (e < N_ENTRIES && tbl[e].group == tbl[first].group) begin
            m       = int'(tbl[e].mst);
            c.write = tbl[e].write;
            c.addr  = tbl[e].addr;
            for (k = 0; k < `SBUS_BURST_LEN; k++) begin
                c.data[k] = $random(seed);
            end
            sent[m]      = c;
            cmd[m]       = c;
            cmd_valid[m] = 1'b1;
            rsp_ready[m] = !tbl[e].slow;
            hold_left[m] = tbl[e].slow ? HOLD_CYCLES : 0;
            has_slow     = has_slow | tbl[e].slow;
            ent[m]       = e;
            step[m]      = S_CMD;
            n_in_group++;
            e++;
        end
        next   = e;
        active = 1'b1;
        while (active) begin
            @(negedge clk);
            active = 1'b0;
            for (m = 0; m < NM; m++) begin
                case (step[m])
                    S_CMD: begin
                        if (!cmd_ready[m]) begin // taken on the last rising edge
                            cmd_valid[m] = 1'b0;
                            step[m]      = S_BUSY;
                        end
                    end
                    S_BUSY: begin
                        if (rsp_valid[m]) begin
                            // no new command until the response is taken
                            check_val($sformatf("cmd_ready[%0d]", m), 136'(0),
                                      136'(cmd_ready[m]));
                            held[m] = rsp[m];
                            check_response(m);
                            for (j = 0; j < NM; j++) begin
                                if (j != m && step[j] == S_HOLD) begin
                                    other_done = 1'b1;
                                end
                            end
                            step[m] = (hold_left[m] > 0) ? S_HOLD : S_TAKE;
                        end
                    end
                    S_HOLD: begin
                        check_val($sformatf("rsp_valid[%0d]", m), 136'(1), 136'(rsp_valid[m]));
                        check_val($sformatf("rsp[%0d]", m), 136'(held[m]), 136'(rsp[m]));
                        hold_left[m]--;
                        if (hold_left[m] == 0) begin
                            rsp_ready[m] = 1'b1;
                            step[m]      = S_TAKE;
                        end
                    end
                    S_TAKE: begin
                        // response gone after the transfer edge
                        check_val($sformatf("rsp_valid[%0d]", m), 136'(0), 136'(rsp_valid[m]));
                        check_val($sformatf("cmd_ready[%0d]", m), 136'(1), 136'(cmd_ready[m]));
                        step[m] = S_OFF;
                    end
                    default: begin
                        step[m] = S_OFF;
                    end
                endcase
                if (step[m] != S_OFF) begin
                    active = 1'b1;
                end
            end
        end
        if (has_slow && n_in_group > 1 && !other_done) begin
            n_errors++;
            $display("no other master completed while a response was held, at %0t", $time);
        end
    endtask

    initial begin
        int i;
        int nxt;
        seed      = 32'h6cf4_3de8;
        n_checks  = 0;
        n_errors  = 0;
        cmd_valid = '0;
        cmd       = '0;
        rsp_ready = '1;
        for (i = 0; i < NM; i++) begin
            step[i]      = S_OFF;
            hold_left[i] = 0;
        end
        for (i = 0; i < `SBUS_MEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        // group, master, write, address, slow
        tbl[0]  = '{4'd0, 2'd0, 1'b0, 6'd10, 1'b0}; // never written
        tbl[1]  = '{4'd1, 2'd1, 1'b1, 6'd20, 1'b0};
        tbl[2]  = '{4'd2, 2'd2, 1'b0, 6'd20, 1'b0};
        tbl[3]  = '{4'd3, 2'd0, 1'b1, 6'd62, 1'b0}; // wraps to 0 and 1
        tbl[4]  = '{4'd4, 2'd1, 1'b0, 6'd0, 1'b0};
        tbl[5]  = '{4'd5, 2'd0, 1'b1, 6'd40, 1'b0}; // all three at once
        tbl[6]  = '{4'd5, 2'd1, 1'b1, 6'd44, 1'b0};
        tbl[7]  = '{4'd5, 2'd2, 1'b1, 6'd48, 1'b0};
        tbl[8]  = '{4'd6, 2'd0, 1'b0, 6'd44, 1'b0};
        tbl[9]  = '{4'd7, 2'd1, 1'b0, 6'd48, 1'b0};
        tbl[10] = '{4'd8, 2'd2, 1'b0, 6'd40, 1'b0}; // master 0 is next in turn
        tbl[11] = '{4'd9, 2'd0, 1'b0, 6'd62, 1'b1};
        tbl[12] = '{4'd9, 2'd1, 1'b1, 6'd8, 1'b0};
        tbl[13] = '{4'd10, 2'd2, 1'b0, 6'd8, 1'b0};
        wait (rst_n === 1'b1);
        @(negedge clk);
        i = 0;
        while (i < N_ENTRIES) begin
            run_group(i, nxt);
            i = nxt;
        end
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: tests still running after %0d cycles, %0d checks, %0d errors",
                 TIMEOUT, n_checks, n_errors);
        $display("Something failed");
        $finish;
    end

endmodule

/* list.f */
+incdir+src
src/sbus_pkg.sv
src/burst_master.sv
src/bus_arbiter.sv
src/burst_slave_mem.sv
src/sbus_top.sv
testbench/clk_gen.sv
testbench/sbus_assertions.sv
testbench/sbus_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the shared burst bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module sbus_tb -f list.f --Mdir "$OBJ" -o sbus_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/sbus_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
